//--- common/sparse_pkg.sv
package sparse_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Operand type
	////////////////////////////////////////////////////////////////////////////

	// Width of one ifm or filter element
	localparam int DATA_W = 8;

	// One packed non-zero operand byte
	typedef logic [DATA_W-1:0] data_t;

	////////////////////////////////////////////////////////////////////////////
	// Chunk buffer FSM
	////////////////////////////////////////////////////////////////////////////

	// FILL takes beats from the write port
	// FULL holds a complete chunk until the selector releases it
	typedef enum logic {
		BUF_FILL,
		BUF_FULL
	} buf_state_e;

	////////////////////////////////////////////////////////////////////////////
	// Input selector FSM
	////////////////////////////////////////////////////////////////////////////

	// IDLE waits for both chunks
	// SCAN emits one matching pair per cycle
	// DRAIN lets the last product land in its output buffer
	// END flags the chunk as done and frees both buffers
	typedef enum logic [1:0] {
		SEL_IDLE,
		SEL_SCAN,
		SEL_DRAIN,
		SEL_END
	} sel_state_e;

endpackage

//--- verilog/chunk_buffer.sv
`timescale 1ns/1ps

module chunk_buffer
	import sparse_pkg::*;
#(
	parameter int MEM_SIZE = 128,
	parameter int BUS_SIZE = 8
) (
	input  logic                        clk_i,
	input  logic                        reset_i,
	input  logic                        wr_valid_i,
	input  logic [BUS_SIZE-1:0]         sparsemap_i,
	input  data_t [BUS_SIZE-1:0]        nonzero_data_i,
	input  logic                        release_i,
	output logic                        wr_ready_o,
	output logic                        full_o,
	output logic [MEM_SIZE-1:0]         map_o,
	output data_t [MEM_SIZE-1:0]        data_o
);

	localparam int BEATS = MEM_SIZE / BUS_SIZE;
	localparam int CNT_W = (BEATS > 1) ? $clog2(BEATS) : 1;

	buf_state_e           state_q;
	logic [CNT_W-1:0]     beat_q;
	logic                 beat_fire;
	logic                 last_beat;
	logic [MEM_SIZE-1:0]  map_q;
	data_t [MEM_SIZE-1:0] data_q;

	assign wr_ready_o = (state_q == BUF_FILL);
	assign full_o     = (state_q == BUF_FULL);
	assign beat_fire  = wr_valid_i && wr_ready_o;
	assign last_beat  = (beat_q == CNT_W'(BEATS - 1));

	// Beat counter and fill state
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state_q <= BUF_FILL;
			beat_q  <= '0;
		end else begin
			case (state_q)
				BUF_FILL: begin
					if (beat_fire) begin
						if (last_beat) begin
							state_q <= BUF_FULL;
							beat_q  <= '0;
						end else begin
							beat_q <= beat_q + 1'b1;
						end
					end
				end
				BUF_FULL: begin
					// Reopen once the selector is done with this chunk
					if (release_i) begin
						state_q <= BUF_FILL;
					end
				end
				default: state_q <= BUF_FILL;
			endcase
		end
	end

	// Beat k lands in positions k*BUS_SIZE upward of both arrays
	always_ff @(posedge clk_i) begin
		if (beat_fire) begin
			map_q[beat_q*BUS_SIZE +: BUS_SIZE]  <= sparsemap_i;
			data_q[beat_q*BUS_SIZE +: BUS_SIZE] <= nonzero_data_i;
		end
	end

	assign map_o  = map_q;
	assign data_o = data_q;

endmodule

//--- input_selector/prefix_sum.sv
`timescale 1ns/1ps

module prefix_sum #(
	parameter int MEM_SIZE        = 128,
	parameter int PREFIX_SUM_SIZE = 8
) (
	input  logic [MEM_SIZE-1:0]          map_i,
	input  logic [$clog2(MEM_SIZE)-1:0]  pos_i,
	output logic [PREFIX_SUM_SIZE-1:0]   index_o
);

	logic [PREFIX_SUM_SIZE-1:0] count;

	////////////////////////////////////////////////////////////////////////////
	// Population count of the map below pos_i
	////////////////////////////////////////////////////////////////////////////

	// Every set bit under the position is one packed byte stored ahead of it,
	// so the count is directly the index into the packed array
	always_comb begin
		count = '0;
		for (int i = 0; i < MEM_SIZE; i++) begin
			if ((i < int'(pos_i)) && map_i[i]) begin
				count = count + 1'b1;
			end
		end
	end

	assign index_o = count;

endmodule

//--- input_selector/input_selector.sv
`timescale 1ns/1ps

module input_selector
	import sparse_pkg::*;
#(
	parameter int MEM_SIZE        = 128,
	parameter int PREFIX_SUM_SIZE = 8
) (
	input  logic                  clk_i,
	input  logic                  reset_i,
	input  logic                  ifm_full_i,
	input  logic                  filter_full_i,
	input  logic [MEM_SIZE-1:0]   ifm_map_i,
	input  logic [MEM_SIZE-1:0]   filter_map_i,
	input  data_t [MEM_SIZE-1:0]  ifm_data_i,
	input  data_t [MEM_SIZE-1:0]  filter_data_i,
	output logic                  release_o,
	output logic                  chunk_start_o,
	output logic                  pair_valid_o,
	output data_t                 ifm_byte_o,
	output data_t                 filter_byte_o,
	output logic                  chunk_end_o
);

	localparam int POS_W = $clog2(MEM_SIZE);

	sel_state_e                 state_q;
	logic [MEM_SIZE-1:0]        pending_q;
	logic [MEM_SIZE-1:0]        scan_src;
	logic [MEM_SIZE-1:0]        scan_rest;
	logic [POS_W-1:0]           low_pos;
	logic                       has_match;
	logic                       start;
	logic                       take;
	logic [PREFIX_SUM_SIZE-1:0] ifm_idx;
	logic [PREFIX_SUM_SIZE-1:0] filter_idx;
	logic                       chunk_start_q;
	logic                       pair_valid_q;
	data_t                      ifm_byte_q;
	data_t                      filter_byte_q;

	assign start = (state_q == SEL_IDLE) && ifm_full_i && filter_full_i;

	// The pair for the next SCAN cycle is prepared one cycle early, so the
	// fresh AND of the maps is used on the IDLE edge and the mask afterwards
	assign scan_src  = (state_q == SEL_IDLE) ? (ifm_map_i & filter_map_i) : pending_q;
	assign has_match = |scan_src;
	assign scan_rest = scan_src & (scan_src - 1'b1);
	assign take      = start || (state_q == SEL_SCAN);

	////////////////////////////////////////////////////////////////////////////
	// Lowest pending position and its packed indices
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		low_pos = '0;
		for (int i = MEM_SIZE - 1; i >= 0; i--) begin
			if (scan_src[i]) begin
				low_pos = POS_W'(i);
			end
		end
	end

	prefix_sum #(
		.MEM_SIZE        (MEM_SIZE),
		.PREFIX_SUM_SIZE (PREFIX_SUM_SIZE)
	) ifm_prefix_sum_i (
		.map_i   (ifm_map_i),
		.pos_i   (low_pos),
		.index_o (ifm_idx)
	);

	prefix_sum #(
		.MEM_SIZE        (MEM_SIZE),
		.PREFIX_SUM_SIZE (PREFIX_SUM_SIZE)
	) filter_prefix_sum_i (
		.map_i   (filter_map_i),
		.pos_i   (low_pos),
		.index_o (filter_idx)
	);

	////////////////////////////////////////////////////////////////////////////
	// Control FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state_q       <= SEL_IDLE;
			pending_q     <= '0;
			chunk_start_q <= 1'b0;
			pair_valid_q  <= 1'b0;
		end else begin
			chunk_start_q <= 1'b0;
			pair_valid_q  <= 1'b0;
			case (state_q)
				SEL_IDLE: begin
					if (start) begin
						state_q       <= SEL_SCAN;
						chunk_start_q <= 1'b1;
						pending_q     <= scan_rest;
						pair_valid_q  <= has_match;
					end
				end
				SEL_SCAN: begin
					pending_q    <= scan_rest;
					pair_valid_q <= has_match;
					// Mask empty so the pair shown now is the last one
					if (!has_match) begin
						state_q <= SEL_DRAIN;
					end
				end
				SEL_DRAIN: state_q <= SEL_END;
				SEL_END:   state_q <= SEL_IDLE;
				default:   state_q <= SEL_IDLE;
			endcase
		end
	end

	// Byte pair registers
	always_ff @(posedge clk_i) begin
		if (take && has_match) begin
			ifm_byte_q    <= ifm_data_i[ifm_idx];
			filter_byte_q <= filter_data_i[filter_idx];
		end
	end

	assign chunk_start_o = chunk_start_q;
	assign pair_valid_o  = pair_valid_q;
	assign ifm_byte_o    = ifm_byte_q;
	assign filter_byte_o = filter_byte_q;
	assign chunk_end_o   = (state_q == SEL_END);
	assign release_o     = (state_q == SEL_END);

endmodule

//--- verilog/mac_accumulator.sv
`timescale 1ns/1ps

module mac_accumulator
	import sparse_pkg::*;
#(
	parameter int OUTPUT_BUF_SIZE = 32,
	parameter int OUTPUT_BUF_NUM  = 32
) (
	input  logic                              clk_i,
	input  logic                              reset_i,
	input  logic                              chunk_start_i,
	input  logic                              pair_valid_i,
	input  data_t                             ifm_byte_i,
	input  data_t                             filter_byte_i,
	input  logic [$clog2(OUTPUT_BUF_NUM)-1:0] acc_buf_sel_i,
	input  logic [$clog2(OUTPUT_BUF_NUM)-1:0] out_buf_sel_i,
	output logic [OUTPUT_BUF_SIZE-1:0]        out_buf_dat_o
);

	localparam int SEL_W = $clog2(OUTPUT_BUF_NUM);

	logic [SEL_W-1:0]           buf_sel_q;
	logic [SEL_W-1:0]           target;
	logic [OUTPUT_BUF_SIZE-1:0] product;
	logic [OUTPUT_BUF_SIZE-1:0] acc_q [OUTPUT_BUF_NUM];

	// First pair of a chunk arrives together with chunk start
	assign target = chunk_start_i ? acc_buf_sel_i : buf_sel_q;

	// Wraps at the accumulator width
	assign product = OUTPUT_BUF_SIZE'(ifm_byte_i) * OUTPUT_BUF_SIZE'(filter_byte_i);

	////////////////////////////////////////////////////////////////////////////
	// Target latch and accumulate
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			buf_sel_q <= '0;
		end else if (chunk_start_i) begin
			buf_sel_q <= acc_buf_sel_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			acc_q <= '{default: '0};
		end else if (pair_valid_i) begin
			acc_q[target] <= acc_q[target] + product;
		end
	end

	// Read-back port
	assign out_buf_dat_o = acc_q[out_buf_sel_i];

endmodule

//--- verilog/compute_unit_top.sv
`timescale 1ns/1ps

module compute_unit_top
	import sparse_pkg::*;
#(
	parameter int MEM_SIZE        = 128,
	parameter int BUS_SIZE        = 8,
	parameter int PREFIX_SUM_SIZE = 8,
	parameter int OUTPUT_BUF_SIZE = 32,
	parameter int OUTPUT_BUF_NUM  = 32
) (
	input  logic                              clk_i,
	input  logic                              reset_i,
	input  logic [BUS_SIZE-1:0]               ifm_sparsemap_i,
	input  data_t [BUS_SIZE-1:0]              ifm_nonzero_data_i,
	input  logic                              ifm_wr_valid_i,
	output logic                              ifm_wr_ready_o,
	input  logic [BUS_SIZE-1:0]               filter_sparsemap_i,
	input  data_t [BUS_SIZE-1:0]              filter_nonzero_data_i,
	input  logic                              filter_wr_valid_i,
	output logic                              filter_wr_ready_o,
	output logic                              chunk_end_o,
	input  logic [$clog2(OUTPUT_BUF_NUM)-1:0] acc_buf_sel_i,
	input  logic [$clog2(OUTPUT_BUF_NUM)-1:0] out_buf_sel_i,
	output logic [OUTPUT_BUF_SIZE-1:0]        out_buf_dat_o
);

	logic                 ifm_full;
	logic                 filter_full;
	logic [MEM_SIZE-1:0]  ifm_map;
	logic [MEM_SIZE-1:0]  filter_map;
	data_t [MEM_SIZE-1:0] ifm_data;
	data_t [MEM_SIZE-1:0] filter_data;
	logic                 release_chunk;
	logic                 chunk_start;
	logic                 pair_valid;
	data_t                ifm_byte;
	data_t                filter_byte;

	////////////////////////////////////////////////////////////////////////////
	// Operand chunk buffers
	////////////////////////////////////////////////////////////////////////////

	chunk_buffer #(
		.MEM_SIZE (MEM_SIZE),
		.BUS_SIZE (BUS_SIZE)
	) ifm_buffer_i (
		.clk_i          (clk_i),
		.reset_i        (reset_i),
		.wr_valid_i     (ifm_wr_valid_i),
		.sparsemap_i    (ifm_sparsemap_i),
		.nonzero_data_i (ifm_nonzero_data_i),
		.release_i      (release_chunk),
		.wr_ready_o     (ifm_wr_ready_o),
		.full_o         (ifm_full),
		.map_o          (ifm_map),
		.data_o         (ifm_data)
	);

	chunk_buffer #(
		.MEM_SIZE (MEM_SIZE),
		.BUS_SIZE (BUS_SIZE)
	) filter_buffer_i (
		.clk_i          (clk_i),
		.reset_i        (reset_i),
		.wr_valid_i     (filter_wr_valid_i),
		.sparsemap_i    (filter_sparsemap_i),
		.nonzero_data_i (filter_nonzero_data_i),
		.release_i      (release_chunk),
		.wr_ready_o     (filter_wr_ready_o),
		.full_o         (filter_full),
		.map_o          (filter_map),
		.data_o         (filter_data)
	);

	// Match walker
	input_selector #(
		.MEM_SIZE        (MEM_SIZE),
		.PREFIX_SUM_SIZE (PREFIX_SUM_SIZE)
	) input_selector_i (
		.clk_i         (clk_i),
		.reset_i       (reset_i),
		.ifm_full_i    (ifm_full),
		.filter_full_i (filter_full),
		.ifm_map_i     (ifm_map),
		.filter_map_i  (filter_map),
		.ifm_data_i    (ifm_data),
		.filter_data_i (filter_data),
		.release_o     (release_chunk),
		.chunk_start_o (chunk_start),
		.pair_valid_o  (pair_valid),
		.ifm_byte_o    (ifm_byte),
		.filter_byte_o (filter_byte),
		.chunk_end_o   (chunk_end_o)
	);

	mac_accumulator #(
		.OUTPUT_BUF_SIZE (OUTPUT_BUF_SIZE),
		.OUTPUT_BUF_NUM  (OUTPUT_BUF_NUM)
	) mac_accumulator_i (
		.clk_i         (clk_i),
		.reset_i       (reset_i),
		.chunk_start_i (chunk_start),
		.pair_valid_i  (pair_valid),
		.ifm_byte_i    (ifm_byte),
		.filter_byte_i (filter_byte),
		.acc_buf_sel_i (acc_buf_sel_i),
		.out_buf_sel_i (out_buf_sel_i),
		.out_buf_dat_o (out_buf_dat_o)
	);

endmodule

//--- tests/compute_unit_assert.sv
`timescale 1ns/1ps

module compute_unit_assert
	import sparse_pkg::*;
(
	input logic       clk_i,
	input logic       reset_i,
	input logic       chunk_end_i,
	input logic       ifm_ready_i,
	input logic       filter_ready_i,
	input buf_state_e ifm_state_i,
	input buf_state_e filter_state_i,
	input logic       pair_valid_i,
	input sel_state_e sel_state_i
);

	// Running count of assertion failures
	int assert_errors = 0;

	// Chunk end is a single-cycle pulse
	end_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
		chunk_end_i |=> !chunk_end_i)
	else begin
		$error("chunk_end_o stayed high for more than one cycle");
		assert_errors++;
	end

	// A full buffer keeps refusing beats until the chunk ends
	ifm_closed: assert property (@(posedge clk_i) disable iff (reset_i)
		((ifm_state_i == BUF_FULL) && !chunk_end_i) |=> !ifm_ready_i)
	else begin
		$error("ifm_wr_ready_o rose while the ifm chunk was still in use");
		assert_errors++;
	end

	filter_closed: assert property (@(posedge clk_i) disable iff (reset_i)
		((filter_state_i == BUF_FULL) && !chunk_end_i) |=> !filter_ready_i)
	else begin
		$error("filter_wr_ready_o rose while the filter chunk was still in use");
		assert_errors++;
	end

	// Pairs only come out while scanning
	pair_in_scan: assert property (@(posedge clk_i) disable iff (reset_i)
		pair_valid_i |-> (sel_state_i == SEL_SCAN))
	else begin
		$error("pair_valid high outside SEL_SCAN");
		assert_errors++;
	end

endmodule

bind compute_unit_top compute_unit_assert compute_unit_assert_i (
	.clk_i          (clk_i),
	.reset_i        (reset_i),
	.chunk_end_i    (chunk_end_o),
	.ifm_ready_i    (ifm_wr_ready_o),
	.filter_ready_i (filter_wr_ready_o),
	.ifm_state_i    (ifm_buffer_i.state_q),
	.filter_state_i (filter_buffer_i.state_q),
	.pair_valid_i   (pair_valid),
	.sel_state_i    (input_selector_i.state_q)
);

//--- tests/compute_unit_tb.sv
`timescale 1ns/1ps

module compute_unit_tb
	import sparse_pkg::*;
();

	localparam int MEM_SIZE        = 128;
	localparam int BUS_SIZE        = 8;
	localparam int OUTPUT_BUF_SIZE = 32;
	localparam int OUTPUT_BUF_NUM  = 32;
	localparam int SEL_W           = $clog2(OUTPUT_BUF_NUM);
	localparam int BEATS           = MEM_SIZE / BUS_SIZE;
	localparam int NUM_TESTS       = 7;
	localparam int ROW_CYCLES      = 2 * MEM_SIZE + 64;

	typedef struct packed {
		logic [7:0]       ifm_thr;
		logic [7:0]       filter_thr;
		logic [SEL_W-1:0] acc_sel;
		logic [SEL_W-1:0] rd_sel;
		logic             late;
		logic             disjoint;
	} row_t;

	logic                       clk_i = 1'b0;
	logic                       reset_i;
	logic [BUS_SIZE-1:0]        ifm_sparsemap_i;
	data_t [BUS_SIZE-1:0]       ifm_nonzero_data_i;
	logic                       ifm_wr_valid_i;
	logic                       ifm_wr_ready_o;
	logic [BUS_SIZE-1:0]        filter_sparsemap_i;
	data_t [BUS_SIZE-1:0]       filter_nonzero_data_i;
	logic                       filter_wr_valid_i;
	logic                       filter_wr_ready_o;
	logic                       chunk_end_o;
	logic [SEL_W-1:0]           acc_buf_sel_i;
	logic [SEL_W-1:0]           out_buf_sel_i;
	logic [OUTPUT_BUF_SIZE-1:0] out_buf_dat_o;

	row_t                       rows [NUM_TESTS];
	string                      row_names [NUM_TESTS];
	int                         row_count = 0;
	data_t                      ifm_dense [MEM_SIZE];
	data_t                      filter_dense [MEM_SIZE];
	data_t                      ifm_packed [MEM_SIZE];
	data_t                      filter_packed [MEM_SIZE];
	logic [MEM_SIZE-1:0]        ifm_map;
	logic [MEM_SIZE-1:0]        filter_map;
	logic [OUTPUT_BUF_SIZE-1:0] expected [OUTPUT_BUF_NUM];
	int                         error_count = 0;
	int                         failed_tests = 0;

	compute_unit_top compute_unit_top_i (.*);

	always #5 clk_i = ~clk_i;

	// Watchdog sized from the number of table rows
	initial begin
		#(10 * ROW_CYCLES * (NUM_TESTS + 2));
		$display("Timeout: the tests did not finish in the allowed time");
		$display("TB FAILED");
		$finish;
	end

	task automatic check_acc(input string name, input logic [OUTPUT_BUF_SIZE-1:0] exp_val,
		input logic [OUTPUT_BUF_SIZE-1:0] act_val);
		if (act_val !== exp_val) begin
			$display("** Error %s: expected %0h, actual %0h", name, exp_val, act_val);
			error_count++;
		end
	endtask

	task automatic check_flag(input string name, input logic exp_val, input logic act_val);
		if (act_val !== exp_val) begin
			$display("** Error %s: expected %b, actual %b", name, exp_val, act_val);
			error_count++;
		end
	endtask

	task automatic add_row(input string name, input row_t row);
		row_names[row_count] = name;
		rows[row_count]      = row;
		row_count++;
	endtask

	// A byte counts as non-zero when it exceeds the density threshold
	task automatic build_chunk(input row_t row);
		int r;
		int ni;
		int nf;
		ni = 0;
		nf = 0;
		for (int p = 0; p < MEM_SIZE; p++) begin
			ifm_packed[p]    = '0;
			filter_packed[p] = '0;
		end
		for (int p = 0; p < MEM_SIZE; p++) begin
			r               = $urandom_range(255, 0);
			ifm_dense[p]    = (r > row.ifm_thr) ? data_t'(r) : '0;
			r               = $urandom_range(255, 0);
			filter_dense[p] = (r > row.filter_thr) ? data_t'(r) : '0;
			if (row.disjoint && (ifm_dense[p] != '0)) begin
				filter_dense[p] = '0;
			end
			ifm_map[p]    = (ifm_dense[p] != '0);
			filter_map[p] = (filter_dense[p] != '0);
			if (ifm_map[p]) begin
				ifm_packed[ni] = ifm_dense[p];
				ni++;
			end
			if (filter_map[p]) begin
				filter_packed[nf] = filter_dense[p];
				nf++;
			end
			// Reference sum over matching positions
			if (ifm_map[p] && filter_map[p]) begin
				expected[row.acc_sel] = expected[row.acc_sel]
					+ OUTPUT_BUF_SIZE'(ifm_dense[p]) * OUTPUT_BUF_SIZE'(filter_dense[p]);
			end
		end
	endtask

	task automatic drive_beat(input logic is_filter, input logic valid, input int k);
		logic [BUS_SIZE-1:0]  map_beat;
		data_t [BUS_SIZE-1:0] data_beat;
		for (int b = 0; b < BUS_SIZE; b++) begin
			map_beat[b]  = is_filter ? filter_map[k*BUS_SIZE + b] : ifm_map[k*BUS_SIZE + b];
			data_beat[b] = is_filter ? filter_packed[k*BUS_SIZE + b] : ifm_packed[k*BUS_SIZE + b];
		end
		if (is_filter) begin
			filter_wr_valid_i     = valid;
			filter_sparsemap_i    = map_beat;
			filter_nonzero_data_i = data_beat;
		end else begin
			ifm_wr_valid_i     = valid;
			ifm_sparsemap_i    = map_beat;
			ifm_nonzero_data_i = data_beat;
		end
	endtask

	// Called 1 ns after an edge and returns 1 ns after the edge taking the last beat
	task automatic send_chunk(input logic is_filter);
		logic rdy;
		for (int k = 0; k < BEATS; k++) begin
			drive_beat(is_filter, 1'b1, k);
			rdy = 1'b0;
			while (!rdy) begin
				rdy = is_filter ? filter_wr_ready_o : ifm_wr_ready_o;
				@(posedge clk_i);
				#1;
			end
		end
		drive_beat(is_filter, 1'b0, 0);
	endtask

	task automatic wait_chunk_end(output logic seen);
		seen = 1'b0;
		for (int c = 0; (c < 2 * MEM_SIZE) && !seen; c++) begin
			if (chunk_end_o) begin
				seen = 1'b1;
			end else begin
				@(posedge clk_i);
				#1;
			end
		end
		if (!seen) begin
			$display("chunk_end_o did not pulse within %0d cycles", 2 * MEM_SIZE);
		end
	endtask

	// Keeps an ifm beat offered against the full buffer until the chunk ends
	task automatic hold_ifm_beat(input string name, output logic seen);
		logic ready_seen;
		ready_seen = 1'b0;
		seen       = 1'b0;
		drive_beat(1'b0, 1'b1, 0);
		for (int c = 0; (c < 4 * MEM_SIZE) && !seen; c++) begin
			ready_seen = ready_seen | ifm_wr_ready_o;
			if (chunk_end_o) begin
				seen = 1'b1;
			end else begin
				@(posedge clk_i);
				#1;
			end
		end
		drive_beat(1'b0, 1'b0, 0);
		check_flag({name, " ifm_wr_ready_o while full"}, 1'b0, ready_seen);
	endtask

	// Select driven 1 ns after an edge, data sampled mid-cycle
	task automatic read_buf(input logic [SEL_W-1:0] sel, output logic [OUTPUT_BUF_SIZE-1:0] val);
		out_buf_sel_i = sel;
		#4;
		val = out_buf_dat_o;
		@(posedge clk_i);
		#1;
	endtask

	task automatic run_row(input int t);
		row_t                       row;
		logic                       seen;
		logic [OUTPUT_BUF_SIZE-1:0] val;
		int                         errs_before;
		row         = rows[t];
		errs_before = error_count;
		build_chunk(row);
		acc_buf_sel_i = row.acc_sel;
		if (row.late) begin
			send_chunk(1'b0);
			fork
				hold_ifm_beat(row_names[t], seen);
				begin
					repeat (12) @(posedge clk_i);
					#1;
					send_chunk(1'b1);
				end
			join
		end else begin
			fork
				send_chunk(1'b0);
				send_chunk(1'b1);
			join
			wait_chunk_end(seen);
		end
		check_flag({row_names[t], " chunk_end_o"}, 1'b1, seen);
		read_buf(row.acc_sel, val);
		check_acc($sformatf("%s buf %0d", row_names[t], row.acc_sel), expected[row.acc_sel], val);
		read_buf(row.rd_sel, val);
		check_acc($sformatf("%s buf %0d", row_names[t], row.rd_sel), expected[row.rd_sel], val);
		if (error_count != errs_before) begin
			failed_tests++;
		end
		$display("%-12s %s", row_names[t], (error_count == errs_before) ? "ok" : "failed");
		@(posedge clk_i);
		#1;
	endtask

	initial begin
		logic [OUTPUT_BUF_SIZE-1:0] val;
		void'($urandom(32'h4660));
		reset_i = 1'b1;
		acc_buf_sel_i = '0;
		out_buf_sel_i = '0;
		ifm_map       = '0;
		filter_map    = '0;
		for (int p = 0; p < MEM_SIZE; p++) begin
			ifm_packed[p]    = '0;
			filter_packed[p] = '0;
		end
		for (int b = 0; b < OUTPUT_BUF_NUM; b++) begin
			expected[b] = '0;
		end
		drive_beat(1'b0, 1'b0, 0);
		drive_beat(1'b1, 1'b0, 0);

		//////////////////////////////////////////////////////////////////////////
		// Stimulus table of thresholds, target, read-back, late filter and disjoint
		//////////////////////////////////////////////////////////////////////////
		add_row("moderate",    {8'd128, 8'd128, 5'd3,  5'd3,  1'b0, 1'b0});
		add_row("disjoint",    {8'd96,  8'd96,  5'd3,  5'd3,  1'b0, 1'b1});
		add_row("accumulate",  {8'd128, 8'd160, 5'd3,  5'd3,  1'b0, 1'b0});
		add_row("other_buf",   {8'd140, 8'd120, 5'd7,  5'd0,  1'b0, 1'b0});
		add_row("isolation",   {8'd100, 8'd150, 5'd7,  5'd3,  1'b0, 1'b0});
		add_row("late_filter", {8'd128, 8'd128, 5'd12, 5'd12, 1'b1, 1'b0});
		add_row("dense",       {8'd16,  8'd32,  5'd12, 5'd7,  1'b0, 1'b0});

		repeat (5) @(posedge clk_i);
		#1;
		reset_i = 1'b0;

		// Idle state straight after reset
		check_flag("reset ifm_wr_ready_o", 1'b1, ifm_wr_ready_o);
		check_flag("reset filter_wr_ready_o", 1'b1, filter_wr_ready_o);
		check_flag("reset chunk_end_o", 1'b0, chunk_end_o);
		for (int b = 0; b < OUTPUT_BUF_NUM; b++) begin
			read_buf(SEL_W'(b), val);
			check_acc($sformatf("reset buf %0d", b), '0, val);
		end
		failed_tests += (error_count != 0);
		$display("%-12s %s", "reset", (error_count == 0) ? "ok" : "failed");
		@(posedge clk_i);
		#1;

		for (int t = 0; t < row_count; t++) begin
			run_row(t);
		end

		error_count += compute_unit_top_i.compute_unit_assert_i.assert_errors;
		$display("%0d tests, %0d failed, %0d errors", row_count + 1, failed_tests, error_count);
		if (error_count == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

//--- verilog.f
common/sparse_pkg.sv
verilog/chunk_buffer.sv
input_selector/prefix_sum.sv
input_selector/input_selector.sv
verilog/mac_accumulator.sv
verilog/compute_unit_top.sv
tests/compute_unit_assert.sv
tests/compute_unit_tb.sv

//--- Bender.yml
package:
  name: sparse_compute_unit

sources:
  - files:
      - common/sparse_pkg.sv
      - verilog/chunk_buffer.sv
      - input_selector/prefix_sum.sv
      - input_selector/input_selector.sv
      - verilog/mac_accumulator.sv
      - verilog/compute_unit_top.sv
  - target: test
    files:
      - tests/compute_unit_assert.sv
      - tests/compute_unit_tb.sv
